/* hdl/xcvr_reconfig_defs.svh */
/*
 * Widths and timing constants shared by the transceiver
 * reconfiguration controller and its testbench.
 */
`ifndef XCVR_RECONFIG_DEFS_SVH
`define XCVR_RECONFIG_DEFS_SVH

// management port, word addressed
`define MGMT_ADDR_W 7
// word offset bits inside one slave slot
`define SLOT_OFS_W 3
`define DATA_W 32

// basic port word address
`define BASIC_ADDR_W 3

// logical channels and their dprio word space
`define NUM_CHANNELS 4
`define DPRIO_ADDR_W 4
`define DPRIO_DATA_W 16
// clocks taken by one dprio read or write
`define DPRIO_OP_CYCLES 8

`endif

/* hdl/reconfig_bus_pkg.sv */
/*
 * Bus types of the reconfiguration controller.
 * Request and response bundles for the management port, the
 * per-slave slot ports and the shared basic port.
 */
`include "xcvr_reconfig_defs.svh"

package reconfig_bus_pkg;

	// management word address split into slave slot and word offset
	typedef struct packed {
		logic [`MGMT_ADDR_W-`SLOT_OFS_W-1:0] slot;
		logic [`SLOT_OFS_W-1:0] ofs;
	} mgmt_addr_t;

	// strobes held until waitrequest is seen low
	typedef struct packed {
		logic read;
		logic write;
		mgmt_addr_t address;
		logic [`DATA_W-1:0] writedata;
	} mgmt_req_t;

	typedef struct packed {
		logic [`DATA_W-1:0] readdata;
		logic waitrequest;
	} mgmt_rsp_t;

	// what a slave sees once the slot bits are stripped
	typedef struct packed {
		logic read;
		logic write;
		logic [`SLOT_OFS_W-1:0] address;
		logic [`DATA_W-1:0] writedata;
	} slot_req_t;

	typedef struct packed {
		logic read;
		logic write;
		logic [`BASIC_ADDR_W-1:0] address;
		logic [`DATA_W-1:0] writedata;
	} basic_req_t;

	typedef struct packed {
		logic [`DATA_W-1:0] readdata;
		logic waitrequest;
	} basic_rsp_t;

endpackage

/* hdl/reconfig_map_pkg.sv */
/*
 * Address map and register layout of the reconfiguration controller.
 * Slave slot numbers, register offsets shared by the analog slave and
 * the basic block, the control word and the calibration rule.
 */
`include "xcvr_reconfig_defs.svh"

package reconfig_map_pkg;

	// management slots, 2 to 15 read as unmapped
	localparam logic [`MGMT_ADDR_W-`SLOT_OFS_W-1:0] SLOT_OFFSET = 0;
	localparam logic [`MGMT_ADDR_W-`SLOT_OFS_W-1:0] SLOT_ANALOG = 1;

	// register offsets, same layout in the analog slave and the basic block
	localparam logic [`SLOT_OFS_W-1:0] REG_CHANNEL = 0;
	localparam logic [`SLOT_OFS_W-1:0] REG_CONTROL = 1;
	localparam logic [`SLOT_OFS_W-1:0] REG_DPRIO_ADDR = 2;
	localparam logic [`SLOT_OFS_W-1:0] REG_DATA = 3;

	// calibration touches one dprio word per channel
	localparam logic [`DPRIO_ADDR_W-1:0] OC_DPRIO_ADDR = 8;
	// bit set in that word once the channel is calibrated
	localparam int OC_CAL_FLAG = 15;

	// control / status word
	typedef struct packed {
		logic [21:0] rsvd_hi;
		logic error;
		logic busy;
		logic [5:0] rsvd_lo;
		logic do_read;
		logic do_write;
	} control_word_t;

endpackage

/* hdl/reconfig_mgmt_decoder.sv */
/*
 * Management port decoder.
 * Splits the word address into slot and offset, steers the strobes
 * to the selected slave and muxes its response back. Unmapped slots
 * answer all ones at once.
 */
`timescale 1ns/100ps

module reconfig_mgmt_decoder (
	input reconfig_bus_pkg::mgmt_req_t mgmt_req,
	output reconfig_bus_pkg::mgmt_rsp_t mgmt_rsp,
	output reconfig_bus_pkg::slot_req_t offset_req,
	input reconfig_bus_pkg::mgmt_rsp_t offset_rsp,
	output reconfig_bus_pkg::slot_req_t analog_req,
	input reconfig_bus_pkg::mgmt_rsp_t analog_rsp
);
	import reconfig_map_pkg::*;

	logic sel_offset;
	logic sel_analog;

	// one-hot slot select, only this module looks at the slot bits
	assign sel_offset = (mgmt_req.address.slot == SLOT_OFFSET);
	assign sel_analog = (mgmt_req.address.slot == SLOT_ANALOG);

	// offset and data go to every slave, strobes only to the selected one
	always_comb begin
		offset_req.read = mgmt_req.read & sel_offset;
		offset_req.write = mgmt_req.write & sel_offset;
		offset_req.address = mgmt_req.address.ofs;
		offset_req.writedata = mgmt_req.writedata;
		analog_req.read = mgmt_req.read & sel_analog;
		analog_req.write = mgmt_req.write & sel_analog;
		analog_req.address = mgmt_req.address.ofs;
		analog_req.writedata = mgmt_req.writedata;
	end

	// response mux
	always_comb begin
		case (mgmt_req.address.slot)
			SLOT_OFFSET: mgmt_rsp = offset_rsp;
			SLOT_ANALOG: mgmt_rsp = analog_rsp;
			default: begin
				// unmapped slot, no wait state
				mgmt_rsp.readdata = '1;
				mgmt_rsp.waitrequest = 1'b0;
			end
		endcase
	end

endmodule

/* hdl/reconfig_offset_cancel.sv */
/*
 * Offset cancellation sequencer.
 * Runs after reset and on a restart command. Each channel is taken
 * under its own grant of the basic port, its offset word is read and
 * written back with the calibration flag set.
 */
`timescale 1ns/100ps
`include "xcvr_reconfig_defs.svh"

module reconfig_offset_cancel (
	input logic mgmt_clk_clk,
	input logic reset,
	input reconfig_bus_pkg::slot_req_t slot,
	output reconfig_bus_pkg::mgmt_rsp_t slot_rsp,
	output reconfig_bus_pkg::basic_req_t basic_req,
	output logic basic_request,
	input logic basic_grant,
	input reconfig_bus_pkg::basic_rsp_t basic_rsp,
	input logic basic_irq,
	output logic busy
);
	import reconfig_map_pkg::*;

	localparam int CH_W = $clog2(`NUM_CHANNELS);

	typedef enum logic [3:0] {
		ST_IDLE, ST_START, ST_REQ, ST_CHAN, ST_ADDR, ST_RDCMD,
		ST_RDWAIT, ST_RDDATA, ST_WRDATA, ST_WRCMD, ST_WRWAIT, ST_NEXT
	} state_t;

	state_t state;
	logic [CH_W-1:0] chan;
	logic [`DPRIO_DATA_W-1:0] cal_word;
	logic [`DPRIO_DATA_W-1:0] wr_word;
	control_word_t cmd;
	control_word_t status;
	logic restart;

	// word 0 is the only register
	assign cmd = control_word_t'(slot.writedata);
	assign restart = slot.write && (slot.address == '0) && cmd.do_write;

	always_comb begin
		status = '0;
		status.busy = busy;
		slot_rsp.readdata = (slot.address == '0) ? status : '0;
		slot_rsp.waitrequest = 1'b0;
	end

	// start and next release the port between channels
	assign busy = (state != ST_IDLE);
	assign basic_request = !(state inside {ST_IDLE, ST_START, ST_NEXT});

	// calibration rule
	always_comb begin
		wr_word = cal_word;
		wr_word[OC_CAL_FLAG] = 1'b1;
	end

	// basic port accesses per state
	always_comb begin
		basic_req = '0;
		case (state)
			ST_CHAN: begin
				basic_req.write = 1'b1;
				basic_req.address = REG_CHANNEL;
				basic_req.writedata[CH_W-1:0] = chan;
			end
			ST_ADDR: begin
				basic_req.write = 1'b1;
				basic_req.address = REG_DPRIO_ADDR;
				basic_req.writedata[`DPRIO_ADDR_W-1:0] = OC_DPRIO_ADDR;
			end
			ST_RDCMD, ST_WRCMD: begin
				basic_req.write = 1'b1;
				basic_req.address = REG_CONTROL;
				basic_req.writedata[0] = (state == ST_WRCMD);
				basic_req.writedata[1] = (state == ST_RDCMD);
			end
			ST_RDDATA: begin
				basic_req.read = 1'b1;
				basic_req.address = REG_DATA;
			end
			ST_WRDATA: begin
				basic_req.write = 1'b1;
				basic_req.address = REG_DATA;
				basic_req.writedata[`DPRIO_DATA_W-1:0] = wr_word;
			end
			default: basic_req = '0;
		endcase
	end

	always_ff @(posedge mgmt_clk_clk) begin
		if (reset) begin
			// calibration kicks off straight out of reset
			state <= ST_START;
			chan <= '0;
		end else begin
			case (state)
				ST_IDLE: if (restart) state <= ST_START;
				ST_START: begin
					chan <= '0;
					state <= ST_REQ;
				end
				ST_REQ: if (basic_grant) state <= ST_CHAN;
				ST_CHAN: if (!basic_rsp.waitrequest) state <= ST_ADDR;
				ST_ADDR: if (!basic_rsp.waitrequest) state <= ST_RDCMD;
				ST_RDCMD: if (!basic_rsp.waitrequest) state <= ST_RDWAIT;
				ST_RDWAIT: if (basic_irq) state <= ST_RDDATA;
				ST_RDDATA: if (!basic_rsp.waitrequest) state <= ST_WRDATA;
				ST_WRDATA: if (!basic_rsp.waitrequest) state <= ST_WRCMD;
				ST_WRCMD: if (!basic_rsp.waitrequest) state <= ST_WRWAIT;
				ST_WRWAIT: if (basic_irq) state <= ST_NEXT;
				ST_NEXT: begin
					if (chan == CH_W'(`NUM_CHANNELS - 1)) begin
						state <= ST_IDLE;
					end else begin
						chan <= chan + 1'b1;
						state <= ST_REQ;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// offset word as read back
	always_ff @(posedge mgmt_clk_clk) begin
		if (state == ST_RDDATA && !basic_rsp.waitrequest)
			cal_word <= basic_rsp.readdata[`DPRIO_DATA_W-1:0];
	end

endmodule

/* hdl/reconfig_analog.sv */
/*
 * Analog controls slave.
 * Channel, dprio address, data and control registers give indirect
 * read and write access to any dprio word of a logical channel
 * through the shared basic port.
 */
`timescale 1ns/100ps
`include "xcvr_reconfig_defs.svh"

module reconfig_analog (
	input logic mgmt_clk_clk,
	input logic reset,
	input reconfig_bus_pkg::slot_req_t slot,
	output reconfig_bus_pkg::mgmt_rsp_t slot_rsp,
	output reconfig_bus_pkg::basic_req_t basic_req,
	output logic basic_request,
	input logic basic_grant,
	input reconfig_bus_pkg::basic_rsp_t basic_rsp,
	input logic basic_irq,
	output logic busy
);
	import reconfig_map_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE, ST_REQ, ST_CHAN, ST_ADDR, ST_DATA, ST_CTRL, ST_WAIT, ST_READ
	} state_t;

	state_t state;
	logic [`DATA_W-1:0] chan_reg;
	logic [`DPRIO_ADDR_W-1:0] addr_reg;
	logic [`DATA_W-1:0] data_reg;
	logic op_read;
	logic error;
	control_word_t cmd;
	control_word_t status;
	logic start;
	logic chan_ok;

	assign cmd = control_word_t'(slot.writedata);
	assign start = slot.write && (slot.address == REG_CONTROL) && !busy &&
		(cmd.do_read || cmd.do_write);
	// out of range channels never reach the basic port
	assign chan_ok = (chan_reg < `NUM_CHANNELS);

	// the port is requested for the whole sequence
	assign busy = (state != ST_IDLE);
	assign basic_request = busy;

	////////////////////////////////////////////////////////////////////////////
	// management side
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		status = '0;
		status.busy = busy;
		status.error = error;
		slot_rsp.waitrequest = 1'b0;
		slot_rsp.readdata = '0;
		case (slot.address)
			REG_CHANNEL: slot_rsp.readdata = chan_reg;
			REG_CONTROL: slot_rsp.readdata = status;
			REG_DPRIO_ADDR: slot_rsp.readdata[`DPRIO_ADDR_W-1:0] = addr_reg;
			REG_DATA: slot_rsp.readdata = data_reg;
			default: slot_rsp.readdata = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// basic port side
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		basic_req = '0;
		case (state)
			ST_CHAN: begin
				basic_req.write = 1'b1;
				basic_req.address = REG_CHANNEL;
				basic_req.writedata = chan_reg;
			end
			ST_ADDR: begin
				basic_req.write = 1'b1;
				basic_req.address = REG_DPRIO_ADDR;
				basic_req.writedata[`DPRIO_ADDR_W-1:0] = addr_reg;
			end
			ST_DATA: begin
				basic_req.write = 1'b1;
				basic_req.address = REG_DATA;
				basic_req.writedata = data_reg;
			end
			ST_CTRL: begin
				basic_req.write = 1'b1;
				basic_req.address = REG_CONTROL;
				basic_req.writedata[0] = !op_read;
				basic_req.writedata[1] = op_read;
			end
			ST_READ: begin
				basic_req.read = 1'b1;
				basic_req.address = REG_DATA;
			end
			default: basic_req = '0;
		endcase
	end

	always_ff @(posedge mgmt_clk_clk) begin
		if (reset) begin
			state <= ST_IDLE;
			chan_reg <= '0;
			addr_reg <= '0;
			data_reg <= '0;
			op_read <= 1'b0;
			error <= 1'b0;
		end else begin
			// registers are frozen while a sequence runs
			if (slot.write && !busy) begin
				case (slot.address)
					REG_CHANNEL: chan_reg <= slot.writedata;
					REG_DPRIO_ADDR: addr_reg <= slot.writedata[`DPRIO_ADDR_W-1:0];
					REG_DATA: data_reg <= slot.writedata;
					default: ;
				endcase
			end
			case (state)
				ST_IDLE: begin
					if (start) begin
						error <= !chan_ok;
						op_read <= cmd.do_read;
						if (chan_ok)
							state <= ST_REQ;
					end
				end
				ST_REQ: if (basic_grant) state <= ST_CHAN;
				ST_CHAN: if (!basic_rsp.waitrequest) state <= ST_ADDR;
				ST_ADDR: begin
					// reads skip the data word
					if (!basic_rsp.waitrequest)
						state <= op_read ? ST_CTRL : ST_DATA;
				end
				ST_DATA: if (!basic_rsp.waitrequest) state <= ST_CTRL;
				ST_CTRL: if (!basic_rsp.waitrequest) state <= ST_WAIT;
				ST_WAIT: if (basic_irq) state <= op_read ? ST_READ : ST_IDLE;
				ST_READ: begin
					if (!basic_rsp.waitrequest) begin
						data_reg <= '0;
						data_reg[`DPRIO_DATA_W-1:0] <= basic_rsp.readdata[`DPRIO_DATA_W-1:0];
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* hdl/basic_port_arbiter.sv */
/*
 * Basic port arbiter and bridge.
 * Fixed priority with the lowest index first. A grant is held until
 * its master drops the request, and only the granted master's bus
 * reaches the basic block.
 */
`timescale 1ns/100ps

module basic_port_arbiter #(
	parameter int NUM_MASTERS = 2
) (
	input logic mgmt_clk_clk,
	input logic reset,
	input logic [NUM_MASTERS-1:0] request,
	input reconfig_bus_pkg::basic_req_t master_req [NUM_MASTERS],
	output logic [NUM_MASTERS-1:0] grant,
	output reconfig_bus_pkg::basic_rsp_t master_rsp [NUM_MASTERS],
	output reconfig_bus_pkg::basic_req_t basic_req,
	input reconfig_bus_pkg::basic_rsp_t basic_rsp
);
	logic [NUM_MASTERS-1:0] first_req;
	logic held;

	// lowest set request bit
	assign first_req = request & (~request + 1'b1);
	// holder still asking
	assign held = |(grant & request);

	// regrant only once the holder lets go
	always_ff @(posedge mgmt_clk_clk) begin
		if (reset)
			grant <= '0;
		else if (!held)
			grant <= first_req;
	end

	// bridge, grant-selected mux instead of wired or
	always_comb begin
		basic_req = '0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			if (grant[i])
				basic_req = master_req[i];
			master_rsp[i].readdata = basic_rsp.readdata;
			// masters without the grant are stalled
			master_rsp[i].waitrequest = grant[i] ? basic_rsp.waitrequest : 1'b1;
		end
	end

endmodule

/* hdl/basic_dprio.sv */
/*
 * Basic reconfiguration block.
 * Register front end at the shared offsets over a per-channel dprio
 * word space. Each operation runs a fixed number of cycles and ends
 * with a one-cycle irq.
 */
`timescale 1ns/100ps
`include "xcvr_reconfig_defs.svh"

module basic_dprio (
	input logic mgmt_clk_clk,
	input logic reset,
	input reconfig_bus_pkg::basic_req_t basic_req,
	output reconfig_bus_pkg::basic_rsp_t basic_rsp,
	output logic irq
);
	import reconfig_map_pkg::*;

	localparam int CH_W = $clog2(`NUM_CHANNELS);
	localparam int CNT_W = $clog2(`DPRIO_OP_CYCLES);
	localparam int WORDS = 2 ** `DPRIO_ADDR_W;

	logic [CH_W-1:0] chan;
	logic [`DPRIO_ADDR_W-1:0] dprio_addr;
	logic [`DPRIO_DATA_W-1:0] data;
	logic [`DPRIO_DATA_W-1:0] dprio_mem [`NUM_CHANNELS][WORDS];
	logic busy;
	logic op_read;
	logic [CNT_W-1:0] op_cnt;
	logic rd_ack;
	control_word_t cmd;
	control_word_t status;
	logic ctrl_wr;
	logic op_start;

	assign cmd = control_word_t'(basic_req.writedata);
	assign ctrl_wr = basic_req.write && (basic_req.address == REG_CONTROL);
	assign op_start = ctrl_wr && !busy && (cmd.do_read || cmd.do_write);

	////////////////////////////////////////////////////////////////////////////
	// slave response
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		status = '0;
		status.busy = busy;
		// one wait state per read, control writes stall while busy
		basic_rsp.waitrequest = (basic_req.read && !rd_ack) || (ctrl_wr && busy);
		basic_rsp.readdata = '0;
		case (basic_req.address)
			REG_CHANNEL: basic_rsp.readdata[CH_W-1:0] = chan;
			REG_CONTROL: basic_rsp.readdata = status;
			REG_DPRIO_ADDR: basic_rsp.readdata[`DPRIO_ADDR_W-1:0] = dprio_addr;
			REG_DATA: basic_rsp.readdata[`DPRIO_DATA_W-1:0] = data;
			default: basic_rsp.readdata = '0;
		endcase
	end

	// second read cycle
	always_ff @(posedge mgmt_clk_clk) begin
		if (reset)
			rd_ack <= 1'b0;
		else
			rd_ack <= basic_req.read && !rd_ack;
	end

	////////////////////////////////////////////////////////////////////////////
	// registers, op timer and dprio space
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge mgmt_clk_clk) begin
		if (reset) begin
			chan <= '0;
			dprio_addr <= '0;
			data <= '0;
			busy <= 1'b0;
			op_read <= 1'b0;
			op_cnt <= '0;
			irq <= 1'b0;
			// channel space comes up cleared
			for (int c = 0; c < `NUM_CHANNELS; c++)
				for (int a = 0; a < WORDS; a++)
					dprio_mem[c][a] <= '0;
		end else begin
			irq <= 1'b0;
			if (basic_req.write) begin
				case (basic_req.address)
					REG_CHANNEL: chan <= basic_req.writedata[CH_W-1:0];
					REG_DPRIO_ADDR: dprio_addr <= basic_req.writedata[`DPRIO_ADDR_W-1:0];
					REG_DATA: data <= basic_req.writedata[`DPRIO_DATA_W-1:0];
					default: ;
				endcase
			end
			if (op_start) begin
				busy <= 1'b1;
				op_read <= cmd.do_read;
				op_cnt <= CNT_W'(`DPRIO_OP_CYCLES - 1);
			end else if (busy) begin
				if (op_cnt == '0) begin
					// op done, busy drops with the irq pulse
					busy <= 1'b0;
					irq <= 1'b1;
					if (op_read)
						data <= dprio_mem[chan][dprio_addr];
					else
						dprio_mem[chan][dprio_addr] <= data;
				end else begin
					op_cnt <= op_cnt - 1'b1;
				end
			end
		end
	end

endmodule

/* hdl/xcvr_reconfig.sv */
/*
 * Transceiver reconfiguration controller, top level.
 * Management accesses are decoded onto the offset cancellation and
 * analog slaves, which both master the shared basic block through a
 * fixed-priority arbiter.
 */
`timescale 1ns/100ps

module xcvr_reconfig (
	input logic mgmt_clk_clk,
	input logic reset,
	input reconfig_bus_pkg::mgmt_req_t mgmt_req,
	output reconfig_bus_pkg::mgmt_rsp_t mgmt_rsp,
	output logic reconfig_done
);
	import reconfig_bus_pkg::*;

	// slave side, one slot port per sub-component
	slot_req_t offset_slot;
	slot_req_t analog_slot;
	mgmt_rsp_t offset_slot_rsp;
	mgmt_rsp_t analog_slot_rsp;

	// master side, index 0 is offset cancellation and wins ties
	basic_req_t master_req [2];
	basic_rsp_t master_rsp [2];
	logic [1:0] request;
	logic [1:0] grant;

	// granted master onto the basic block
	basic_req_t basic_req;
	basic_rsp_t basic_rsp;
	logic basic_irq;

	logic offset_busy;
	logic analog_busy;

	////////////////////////////////////////////////////////////////////////////
	// management decode
	////////////////////////////////////////////////////////////////////////////
	reconfig_mgmt_decoder decoder0 (
		.mgmt_req(mgmt_req),
		.mgmt_rsp(mgmt_rsp),
		.offset_req(offset_slot),
		.offset_rsp(offset_slot_rsp),
		.analog_req(analog_slot),
		.analog_rsp(analog_slot_rsp)
	);

	////////////////////////////////////////////////////////////////////////////
	// sub-components
	////////////////////////////////////////////////////////////////////////////
	reconfig_offset_cancel offset0 (
		.mgmt_clk_clk(mgmt_clk_clk),
		.reset(reset),
		.slot(offset_slot),
		.slot_rsp(offset_slot_rsp),
		.basic_req(master_req[0]),
		.basic_request(request[0]),
		.basic_grant(grant[0]),
		.basic_rsp(master_rsp[0]),
		.basic_irq(basic_irq),
		.busy(offset_busy)
	);

	reconfig_analog analog0 (
		.mgmt_clk_clk(mgmt_clk_clk),
		.reset(reset),
		.slot(analog_slot),
		.slot_rsp(analog_slot_rsp),
		.basic_req(master_req[1]),
		.basic_request(request[1]),
		.basic_grant(grant[1]),
		.basic_rsp(master_rsp[1]),
		.basic_irq(basic_irq),
		.busy(analog_busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// arbiter and basic block
	////////////////////////////////////////////////////////////////////////////
	basic_port_arbiter #(
		.NUM_MASTERS(2)
	) arbiter0 (
		.mgmt_clk_clk(mgmt_clk_clk),
		.reset(reset),
		.request(request),
		.master_req(master_req),
		.grant(grant),
		.master_rsp(master_rsp),
		.basic_req(basic_req),
		.basic_rsp(basic_rsp)
	);

	basic_dprio basic0 (
		.mgmt_clk_clk(mgmt_clk_clk),
		.reset(reset),
		.basic_req(basic_req),
		.basic_rsp(basic_rsp),
		.irq(basic_irq)
	);

	// done once no sub-component has work in flight
	assign reconfig_done = ~(offset_busy | analog_busy);

endmodule

/* sim/xcvr_reconfig_assert.sv */
/*
 * Bound checker for the reconfiguration controller.
 * Shadows the analog registers and the dprio words from management
 * writes and checks every management response against the shadow.
 */
`timescale 1ns/100ps
`include "xcvr_reconfig_defs.svh"

module xcvr_reconfig_assert (
	input logic mgmt_clk_clk,
	input logic reset,
	input reconfig_bus_pkg::mgmt_req_t mgmt_req,
	input reconfig_bus_pkg::mgmt_rsp_t mgmt_rsp,
	input logic reconfig_done,
	input logic analog_busy
);
	import reconfig_map_pkg::*;

	localparam int CH_W = $clog2(`NUM_CHANNELS);
	localparam int WORDS = 2 ** `DPRIO_ADDR_W;
	// generous bound on a full calibration pass, 60 cycles per channel
	localparam int CAL_LIMIT = `NUM_CHANNELS * 60;
	localparam logic [`DPRIO_DATA_W-1:0] CAL_WORD = `DPRIO_DATA_W'(1) << OC_CAL_FLAG;

	int error_count = 0;
	int cal_cycles;
	logic cal_seen;
	logic [`DATA_W-1:0] chan_shadow;
	logic [`DPRIO_ADDR_W-1:0] addr_shadow;
	logic [`DATA_W-1:0] data_shadow;
	logic err_shadow;
	logic [`DPRIO_DATA_W-1:0] dprio_shadow [`NUM_CHANNELS][WORDS];
	control_word_t cmd;
	control_word_t ctrl_expect;
	logic an_rd;
	logic an_wr;
	logic an_start;
	logic chan_valid;
	logic unmapped_rd;
	logic oc_restart;

	assign cmd = control_word_t'(mgmt_req.writedata);
	assign an_rd = mgmt_req.read && (mgmt_req.address.slot == SLOT_ANALOG);
	assign an_wr = mgmt_req.write && (mgmt_req.address.slot == SLOT_ANALOG);
	assign an_start = an_wr && (mgmt_req.address.ofs == REG_CONTROL) && !analog_busy &&
		(cmd.do_read || cmd.do_write);
	assign chan_valid = (chan_shadow < `NUM_CHANNELS);
	assign unmapped_rd = mgmt_req.read && (mgmt_req.address.slot > SLOT_ANALOG);
	// restart command while everything is idle
	assign oc_restart = mgmt_req.write && (mgmt_req.address.slot == SLOT_OFFSET) &&
		(mgmt_req.address.ofs == '0) && cmd.do_write && reconfig_done;

	always_comb begin
		ctrl_expect = '0;
		ctrl_expect.busy = analog_busy;
		ctrl_expect.error = err_shadow;
	end

	////////////////////////////////////////////////////////////////////////////
	// shadow model
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge mgmt_clk_clk) begin
		if (reset) begin
			chan_shadow <= '0;
			addr_shadow <= '0;
			data_shadow <= '0;
			err_shadow <= 1'b0;
			cal_cycles <= 0;
			cal_seen <= 1'b0;
			// words start at zero, calibration then sets the flag in the offset word
			for (int c = 0; c < `NUM_CHANNELS; c++)
				for (int a = 0; a < WORDS; a++)
					dprio_shadow[c][a] <= (a == int'(OC_DPRIO_ADDR)) ? CAL_WORD : '0;
		end else begin
			cal_seen <= cal_seen | reconfig_done;
			if (!cal_seen)
				cal_cycles <= cal_cycles + 1;
			if (an_wr && !analog_busy) begin
				case (mgmt_req.address.ofs)
					REG_CHANNEL: chan_shadow <= mgmt_req.writedata;
					REG_DPRIO_ADDR: addr_shadow <= mgmt_req.writedata[`DPRIO_ADDR_W-1:0];
					REG_DATA: data_shadow <= mgmt_req.writedata;
					default: ;
				endcase
			end
			if (an_start) begin
				err_shadow <= !chan_valid;
				// read wins when both command bits are set
				if (chan_valid && cmd.do_read)
					data_shadow <= `DATA_W'(dprio_shadow[chan_shadow[CH_W-1:0]][addr_shadow]);
				else if (chan_valid)
					dprio_shadow[chan_shadow[CH_W-1:0]][addr_shadow] <=
						data_shadow[`DPRIO_DATA_W-1:0];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////
	a_done_low: assert property (@(posedge mgmt_clk_clk) $fell(reset) |-> !reconfig_done)
		else begin
			error_count++;
			$error("[ERROR] reconfig_done = %h after reset, expected 0",
				$sampled(reconfig_done));
		end

	a_cal_time: assert property (@(posedge mgmt_clk_clk) disable iff (reset)
		!cal_seen |-> cal_cycles < CAL_LIMIT)
		else begin
			error_count++;
			$error("[ERROR] reconfig_done = %h after %h cycles, expected 1",
				$sampled(reconfig_done), $sampled(cal_cycles));
		end

	// calibration reruns on a restart command
	a_restart: assert property (@(posedge mgmt_clk_clk) disable iff (reset)
		oc_restart |=> !reconfig_done)
		else begin
			error_count++;
			$error("[ERROR] reconfig_done = %h after restart, expected 0",
				$sampled(reconfig_done));
		end

	a_no_wait: assert property (@(posedge mgmt_clk_clk) disable iff (reset)
		(mgmt_req.read || mgmt_req.write) |-> !mgmt_rsp.waitrequest)
		else begin
			error_count++;
			$error("[ERROR] mgmt_rsp.waitrequest = %h, expected 0",
				$sampled(mgmt_rsp.waitrequest));
		end

	a_unmapped: assert property (@(posedge mgmt_clk_clk) disable iff (reset)
		unmapped_rd |-> mgmt_rsp.readdata == '1)
		else begin
			error_count++;
			$error("[ERROR] mgmt_rsp.readdata = %h, expected ffffffff",
				$sampled(mgmt_rsp.readdata));
		end

	a_chan: assert property (@(posedge mgmt_clk_clk) disable iff (reset)
		an_rd && mgmt_req.address.ofs == REG_CHANNEL |-> mgmt_rsp.readdata == chan_shadow)
		else begin
			error_count++;
			$error("[ERROR] mgmt_rsp.readdata = %h, expected channel %h",
				$sampled(mgmt_rsp.readdata), $sampled(chan_shadow));
		end

	a_addr: assert property (@(posedge mgmt_clk_clk) disable iff (reset)
		an_rd && mgmt_req.address.ofs == REG_DPRIO_ADDR |->
		mgmt_rsp.readdata == `DATA_W'(addr_shadow))
		else begin
			error_count++;
			$error("[ERROR] mgmt_rsp.readdata = %h, expected dprio address %h",
				$sampled(mgmt_rsp.readdata), $sampled(addr_shadow));
		end

	// data only settles once the sequence is over
	a_data: assert property (@(posedge mgmt_clk_clk) disable iff (reset)
		an_rd && mgmt_req.address.ofs == REG_DATA && !analog_busy |->
		mgmt_rsp.readdata == data_shadow)
		else begin
			error_count++;
			$error("[ERROR] mgmt_rsp.readdata = %h, expected data %h",
				$sampled(mgmt_rsp.readdata), $sampled(data_shadow));
		end

	a_ctrl: assert property (@(posedge mgmt_clk_clk) disable iff (reset)
		an_rd && mgmt_req.address.ofs == REG_CONTROL |-> mgmt_rsp.readdata == ctrl_expect)
		else begin
			error_count++;
			$error("[ERROR] mgmt_rsp.readdata = %h, expected control %h",
				$sampled(mgmt_rsp.readdata), $sampled(ctrl_expect));
		end

	// bad channel never starts a sequence
	a_bad_chan: assert property (@(posedge mgmt_clk_clk) disable iff (reset)
		an_start && !chan_valid |=> !analog_busy && reconfig_done)
		else begin
			error_count++;
			$error("[ERROR] analog_busy = %h, reconfig_done = %h, expected 0 and 1",
				$sampled(analog_busy), $sampled(reconfig_done));
		end

endmodule

bind xcvr_reconfig xcvr_reconfig_assert assert0 (
	.mgmt_clk_clk(mgmt_clk_clk),
	.reset(reset),
	.mgmt_req(mgmt_req),
	.mgmt_rsp(mgmt_rsp),
	.reconfig_done(reconfig_done),
	.analog_busy(analog_busy)
);

/* sim/tb_xcvr_reconfig.sv */
/*
 * Testbench for the transceiver reconfiguration controller.
 * Drives management traffic on the falling edge and reaches the bound
 * assertions, which do all the checking. Ends with the error count.
 */
`timescale 1ns/100ps
`include "xcvr_reconfig_defs.svh"

module tb_xcvr_reconfig;
	import reconfig_bus_pkg::*;
	import reconfig_map_pkg::*;

	localparam int SLOT_W = `MGMT_ADDR_W - `SLOT_OFS_W;
	// two calibration runs plus about 20 accesses of up to 60 cycles, with margin
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int NUM_PAIRS = 6;

	logic clk = 1'b0;
	logic reset;
	mgmt_req_t mgmt_req;
	mgmt_rsp_t mgmt_rsp;
	logic reconfig_done;
	int cycle_count;

	xcvr_reconfig dut0 (
		.mgmt_clk_clk(clk),
		.reset(reset),
		.mgmt_req(mgmt_req),
		.mgmt_rsp(mgmt_rsp),
		.reconfig_done(reconfig_done)
	);

	// 4 ns period
	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// management access tasks
	////////////////////////////////////////////////////////////////////////////

	// strobe held until waitrequest is seen low, then released
	task automatic mgmt_access(input logic rd, input logic [SLOT_W-1:0] slot,
		input logic [`SLOT_OFS_W-1:0] ofs, input logic [`DATA_W-1:0] wdata,
		output logic [`DATA_W-1:0] rdata);
		@(negedge clk);
		mgmt_req.read = rd;
		mgmt_req.write = !rd;
		mgmt_req.address.slot = slot;
		mgmt_req.address.ofs = ofs;
		mgmt_req.writedata = wdata;
		// response is settled halfway through the low phase
		#1;
		while (mgmt_rsp.waitrequest) begin
			@(negedge clk);
			#1;
		end
		rdata = mgmt_rsp.readdata;
		@(negedge clk);
		mgmt_req = '0;
	endtask

	task automatic mgmt_write(input logic [SLOT_W-1:0] slot,
		input logic [`SLOT_OFS_W-1:0] ofs, input logic [`DATA_W-1:0] data);
		logic [`DATA_W-1:0] unused;
		mgmt_access(1'b0, slot, ofs, data, unused);
	endtask

	task automatic mgmt_read(input logic [SLOT_W-1:0] slot,
		input logic [`SLOT_OFS_W-1:0] ofs, output logic [`DATA_W-1:0] data);
		mgmt_access(1'b1, slot, ofs, '0, data);
	endtask

	// poll a control word until its busy bit drops
	task automatic wait_not_busy(input logic [SLOT_W-1:0] slot,
		input logic [`SLOT_OFS_W-1:0] ofs);
		logic [`DATA_W-1:0] word;
		control_word_t status;
		do begin
			mgmt_read(slot, ofs, word);
			status = control_word_t'(word);
		end while (status.busy);
	endtask

	// one indirect dprio access through the analog slave
	task automatic analog_op(input logic rd, input logic [`DATA_W-1:0] chan,
		input logic [`DPRIO_ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
		control_word_t cmd;
		logic [`DATA_W-1:0] word;
		cmd = '0;
		cmd.do_read = rd;
		cmd.do_write = !rd;
		mgmt_write(SLOT_ANALOG, REG_CHANNEL, chan);
		mgmt_write(SLOT_ANALOG, REG_DPRIO_ADDR, `DATA_W'(addr));
		if (!rd)
			mgmt_write(SLOT_ANALOG, REG_DATA, data);
		mgmt_write(SLOT_ANALOG, REG_CONTROL, cmd);
		wait_not_busy(SLOT_ANALOG, REG_CONTROL);
		// data word compared with the shadow
		mgmt_read(SLOT_ANALOG, REG_DATA, word);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////
	initial begin
		logic [`DATA_W-1:0] word;
		logic [`DATA_W-1:0] chan;
		logic [`DPRIO_ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
		void'($urandom(32'hcca8_51db));
		mgmt_req = '0;
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// calibration runs on its own after reset
		while (!reconfig_done)
			@(negedge clk);

		// every unmapped slot
		for (int s = 2; s < 2 ** SLOT_W; s++)
			mgmt_read(SLOT_W'(s), `SLOT_OFS_W'($urandom), word);

		// plain register readback
		mgmt_write(SLOT_ANALOG, REG_CHANNEL, `DATA_W'($urandom % `NUM_CHANNELS));
		mgmt_read(SLOT_ANALOG, REG_CHANNEL, word);
		mgmt_write(SLOT_ANALOG, REG_DPRIO_ADDR, `DATA_W'($urandom));
		mgmt_read(SLOT_ANALOG, REG_DPRIO_ADDR, word);

		// write then read back the same word, offset word left alone
		repeat (NUM_PAIRS) begin
			chan = `DATA_W'($urandom % `NUM_CHANNELS);
			addr = `DPRIO_ADDR_W'($urandom);
			if (addr == OC_DPRIO_ADDR)
				addr = addr ^ `DPRIO_ADDR_W'(1);
			data = $urandom;
			analog_op(1'b0, chan, addr, data);
			analog_op(1'b1, chan, addr, '0);
		end

		// calibrated offset word on every channel
		for (int c = 0; c < `NUM_CHANNELS; c++)
			analog_op(1'b1, `DATA_W'(c), OC_DPRIO_ADDR, '0);

		// restart calibration, the flag is already set
		mgmt_write(SLOT_OFFSET, '0, `DATA_W'(1));
		wait_not_busy(SLOT_OFFSET, '0);
		for (int c = 0; c < `NUM_CHANNELS; c++)
			analog_op(1'b1, `DATA_W'(c), OC_DPRIO_ADDR, '0);

		// out of range channel, then a good access to clear error
		chan = `DATA_W'(`NUM_CHANNELS + ($urandom % 4));
		analog_op(1'b1, chan, `DPRIO_ADDR_W'($urandom), '0);
		analog_op(1'b0, `DATA_W'(0), `DPRIO_ADDR_W'(1), $urandom);

		$display("tb_xcvr_reconfig done, assertion errors: %0d", dut0.assert0.error_count);
		if (dut0.assert0.error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

/* xcvr_reconfig.f */
+incdir+hdl
hdl/reconfig_bus_pkg.sv
hdl/reconfig_map_pkg.sv
hdl/reconfig_mgmt_decoder.sv
hdl/reconfig_offset_cancel.sv
hdl/reconfig_analog.sv
hdl/basic_port_arbiter.sv
hdl/basic_dprio.sv
hdl/xcvr_reconfig.sv
sim/xcvr_reconfig_assert.sv
sim/tb_xcvr_reconfig.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_xcvr_reconfig
FILELIST = xcvr_reconfig.f
OBJ_DIR = obj_dir
LOG = sim.log
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
